/* hdl/arxFilterPkg.sv */
package arxFilterPkg;

	localparam int NumCoeffs = 20; // ten input terms, ten output terms.
	localparam int NumHist = 10;

	typedef logic [8:0] addrT; // byte address on the register bus.
	typedef logic [4:0] coeffIdxT;
	typedef logic [3:0] histIdxT;

	// word addresses, all aligned to 4.
	localparam addrT AddrStatus = 9'h000;
	localparam addrT AddrResult = 9'h004;
	localparam addrT AddrError = 9'h008;
	localparam addrT AddrCoeffBase = 9'h00C; // coeff 0 to 19.
	localparam addrT AddrOffset = 9'h05C;
	localparam addrT AddrSample = 9'h060;
	localparam addrT AddrHistBase = 9'h064; // Y0 to Y9, Y0 is the previous result.

endpackage

/* hdl/arxFilterIfs.sv */
`timescale 1ns/1ps

interface regWriteIf #(
	parameter int Width = 16
);
	logic coeffWe;
	arxFilterPkg::coeffIdxT coeffIdx;
	logic offsetWe;
	logic sampleWe; // starts one filter step.
	logic signed [Width-1:0] wrData;

	modport source(output coeffWe, coeffIdx, offsetWe, sampleWe, wrData);
	modport sink(input coeffWe, coeffIdx, offsetWe, sampleWe, wrData);
endinterface

interface filterStateIf #(
	parameter int Width = 16
);
	logic signed [Width-1:0] coeff [arxFilterPkg::NumCoeffs];
	logic signed [Width-1:0] offset;
	logic signed [Width-1:0] sample;
	logic signed [Width-1:0] yHist [arxFilterPkg::NumHist];
	logic signed [Width-1:0] result;
	logic listo;
	logic error; // last step saturated.

	modport source(output coeff, offset, sample, yHist, result, listo, error);
	modport sink(input coeff, offset, sample, yHist, result, listo, error);
endinterface

/* hdl/writeDecode.sv */
`timescale 1ns/1ps

module writeDecode #(
	parameter int Width = 16
) (
	input logic clk,
	input logic Write,
	input arxFilterPkg::addrT Address,
	input logic signed [Width-1:0] WrDato,
	input logic busy,
	regWriteIf.source regWr
);

	arxFilterPkg::addrT coeffOff;
	logic coeffHit;
	logic accept;

	// below the base the subtraction wraps high, so one compare covers the range.
	assign coeffOff = Address - arxFilterPkg::AddrCoeffBase;
	assign coeffHit = (coeffOff < arxFilterPkg::addrT'(4 * arxFilterPkg::NumCoeffs)) &&
		(Address[1:0] == 2'b00);

	assign accept = Write && !busy; // writes during a step are dropped here.

	// strobes are registered, so each lasts exactly one cycle.
	always_ff @(posedge clk) begin
		regWr.coeffWe <= accept && coeffHit;
		regWr.coeffIdx <= arxFilterPkg::coeffIdxT'(coeffOff >> 2);
		regWr.offsetWe <= accept && (Address == arxFilterPkg::AddrOffset);
		regWr.sampleWe <= accept && (Address == arxFilterPkg::AddrSample);
		regWr.wrData <= WrDato;
	end

endmodule

/* hdl/arxExecute.sv */
`timescale 1ns/1ps

module arxExecute #(
	parameter int Width = 16,
	parameter int FracBits = 8
) (
	input logic clk,
	input logic rst,
	regWriteIf.sink regWr,
	filterStateIf.source state,
	output logic busy
);

	localparam int NumCoeffs = arxFilterPkg::NumCoeffs;
	localparam int NumHist = arxFilterPkg::NumHist;
	localparam int AccWidth = 2 * Width + 5; // twenty full-scale products fit.

	// signed Width limits, extended to the accumulator width.
	localparam logic signed [AccWidth-1:0] MaxVal =
		{{(AccWidth - Width + 1){1'b0}}, {(Width - 1){1'b1}}};
	localparam logic signed [AccWidth-1:0] MinVal =
		{{(AccWidth - Width + 1){1'b1}}, {(Width - 1){1'b0}}};

	typedef enum logic [1:0] {
		idle,
		accumulate,
		finish
	} seqT;

	seqT seq;
	arxFilterPkg::coeffIdxT idx;
	arxFilterPkg::histIdxT hIdx;
	logic signed [Width-1:0] coeff [NumCoeffs];
	logic signed [Width-1:0] xHist [NumHist]; // xHist[0] is the latest sample.
	logic signed [Width-1:0] yHist [NumHist];
	logic signed [Width-1:0] offset;
	logic signed [Width-1:0] result;
	logic signed [Width-1:0] operand;
	logic signed [2*Width-1:0] product;
	logic signed [AccWidth-1:0] acc;
	logic signed [AccWidth-1:0] scaled;
	logic listo;
	logic error;
	logic overMax;
	logic underMin;

	// coefficients 0..9 use input history, 10..19 use output history.
	assign hIdx = (idx < NumHist) ? arxFilterPkg::histIdxT'(idx) :
		arxFilterPkg::histIdxT'(idx - NumHist);
	assign operand = (idx < NumHist) ? xHist[hIdx] : yHist[hIdx];
	assign product = coeff[idx] * operand;

	assign scaled = (acc >>> FracBits) + offset;
	assign overMax = scaled > MaxVal;
	assign underMin = scaled < MinVal;

	assign busy = (seq != idle) || regWr.sampleWe; // a pending sample counts too.

	always_ff @(posedge clk) begin
		if (rst) begin
			seq <= idle;
			idx <= '0;
			acc <= '0;
			offset <= '0;
			result <= '0;
			listo <= 1'b1;
			error <= 1'b0;
			for (int i = 0; i < NumCoeffs; i++) begin
				coeff[i] <= '0;
			end
			for (int i = 0; i < NumHist; i++) begin
				xHist[i] <= '0;
				yHist[i] <= '0;
			end
		end else begin
			if (regWr.coeffWe) coeff[regWr.coeffIdx] <= regWr.wrData;
			if (regWr.offsetWe) offset <= regWr.wrData;
			case (seq)
				idle: begin
					if (regWr.sampleWe) begin
						xHist[0] <= regWr.wrData;
						yHist[0] <= result; // previous result becomes Y0.
						for (int i = 1; i < NumHist; i++) begin
							xHist[i] <= xHist[i-1];
							yHist[i] <= yHist[i-1];
						end
						acc <= '0;
						idx <= '0;
						listo <= 1'b0;
						seq <= accumulate;
					end
				end
				accumulate: begin
					acc <= acc + product; // one term per cycle.
					if (idx == NumCoeffs - 1) begin
						idx <= '0;
						seq <= finish;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				finish: begin
					if (overMax) begin
						result <= MaxVal[Width-1:0];
						error <= 1'b1;
					end else if (underMin) begin
						result <= MinVal[Width-1:0];
						error <= 1'b1;
					end else begin
						result <= scaled[Width-1:0];
						error <= 1'b0;
					end
					listo <= 1'b1;
					seq <= idle;
				end
				default: seq <= idle;
			endcase
		end
	end

	assign state.coeff = coeff;
	assign state.offset = offset;
	assign state.sample = xHist[0];
	assign state.yHist = yHist;
	assign state.result = result;
	assign state.listo = listo;
	assign state.error = error;

endmodule

/* hdl/readbackMux.sv */
`timescale 1ns/1ps

module readbackMux #(
	parameter int Width = 16
) (
	input logic Read,
	input arxFilterPkg::addrT Address,
	filterStateIf.sink state,
	output logic signed [Width-1:0] RdDato
);

	arxFilterPkg::addrT coeffOff;
	arxFilterPkg::addrT histOff;
	arxFilterPkg::coeffIdxT coeffIdx;
	arxFilterPkg::histIdxT histIdx;
	logic aligned;
	logic coeffHit;
	logic histHit;

	assign aligned = Address[1:0] == 2'b00;

	// offsets wrap high below each base, so a single bound is enough.
	assign coeffOff = Address - arxFilterPkg::AddrCoeffBase;
	assign histOff = Address - arxFilterPkg::AddrHistBase;
	assign coeffHit = aligned &&
		(coeffOff < arxFilterPkg::addrT'(4 * arxFilterPkg::NumCoeffs));
	assign histHit = aligned &&
		(histOff < arxFilterPkg::addrT'(4 * arxFilterPkg::NumHist));
	assign coeffIdx = arxFilterPkg::coeffIdxT'(coeffOff >> 2);
	assign histIdx = arxFilterPkg::histIdxT'(histOff >> 2);

	always_comb begin
		RdDato = '0; // also the value for unmapped addresses.
		if (Read) begin
			if (Address == arxFilterPkg::AddrStatus) begin
				RdDato = Width'(state.listo);
			end else if (Address == arxFilterPkg::AddrResult) begin
				RdDato = state.result;
			end else if (Address == arxFilterPkg::AddrError) begin
				RdDato = Width'(state.error);
			end else if (coeffHit) begin
				RdDato = state.coeff[coeffIdx];
			end else if (Address == arxFilterPkg::AddrOffset) begin
				RdDato = state.offset;
			end else if (Address == arxFilterPkg::AddrSample) begin
				RdDato = state.sample;
			end else if (histHit) begin
				RdDato = state.yHist[histIdx]; // Y0 first.
			end
		end
	end

endmodule

/* hdl/arxFilterTop.sv */
`timescale 1ns/1ps

module arxFilterTop #(
	parameter int Width = 16,
	parameter int FracBits = 8
) (
	input logic clk,
	input logic rst,
	input logic Write,
	input logic Read,
	input arxFilterPkg::addrT Address,
	input logic signed [Width-1:0] WrDato,
	output logic signed [Width-1:0] RdDato,
	output logic Listo
);

	logic busy;

	regWriteIf #(.Width(Width)) regWr ();
	filterStateIf #(.Width(Width)) state ();

	writeDecode #(.Width(Width)) decode (
		.clk(clk),
		.Write(Write),
		.Address(Address),
		.WrDato(WrDato),
		.busy(busy),
		.regWr(regWr.source)
	);

	arxExecute #(.Width(Width), .FracBits(FracBits)) execute (
		.clk(clk),
		.rst(rst),
		.regWr(regWr.sink),
		.state(state.source),
		.busy(busy)
	);

	readbackMux #(.Width(Width)) readback (
		.Read(Read),
		.Address(Address),
		.state(state.sink),
		.RdDato(RdDato)
	);

	assign Listo = state.listo;

endmodule

/* bench/arxFilterTb_properties.sv */
`timescale 1ns/1ps

module arxFilterTb_properties #(
	parameter int Width = 16
) (
	input logic clk,
	input logic rst,
	input logic Write,
	input logic Read,
	input arxFilterPkg::addrT Address,
	input logic signed [Width-1:0] RdDato,
	input logic Listo
);

	logic stepStart;
	int failCount = 0;

	// a sample write that arrives while the filter is ready.
	assign stepStart = Write && (Address == arxFilterPkg::AddrSample) && Listo;

	readIdleZero: assert property (@(posedge clk) !Read |-> RdDato == '0)
		else begin
			$error("RdDato is not zero while Read is low");
			failCount++;
		end

	// a second write right behind the first is dropped by the decoder.
	stepLength: assert property (@(posedge clk) disable iff (rst)
		stepStart && !$past(stepStart) |=> Listo ##1 !Listo [*21] ##1 Listo)
		else begin
			$error("Listo did not stay low for the length of one filter step");
			failCount++;
		end

	resetReady: assert property (@(posedge clk) rst |=> Listo)
		else begin
			$error("Listo is not high after reset");
			failCount++;
		end

endmodule

bind arxFilterTop arxFilterTb_properties #(.Width(Width)) props (
	.clk(clk), .rst(rst), .Write(Write), .Read(Read),
	.Address(Address), .RdDato(RdDato), .Listo(Listo)
);

/* bench/arxFilterTb.sv */
`timescale 1ns/1ps

module arxFilterTb;

	localparam int Width = 16;
	localparam int FracBits = 8;
	localparam int Period = 20;
	localparam int OpBudget = 22 + 4; // worst case cycles for one operation.

	logic clk;
	logic rst;
	logic Write;
	logic Read;
	arxFilterPkg::addrT Address;
	logic signed [Width-1:0] WrDato;
	logic signed [Width-1:0] RdDato;
	logic Listo;

	logic [7:0] opQ [$];
	arxFilterPkg::addrT addrQ [$];
	logic signed [Width-1:0] valQ [$];
	integer seed;
	int numOps;
	int checkCount;
	int errorCount;
	logic loaded;

	arxFilterTop #(.Width(Width), .FracBits(FracBits)) u_dut (
		.clk(clk),
		.rst(rst),
		.Write(Write),
		.Read(Read),
		.Address(Address),
		.WrDato(WrDato),
		.RdDato(RdDato),
		.Listo(Listo)
	);

	initial begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk;
	end

	task automatic checkData(input string name, input logic signed [Width-1:0] expected,
		input logic signed [Width-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s at 0x%h: expected 0x%h, got 0x%h", name, Address, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
		end
	endtask

	task automatic loadOps();
		integer fd;
		integer code;
		logic [7:0] opChar;
		arxFilterPkg::addrT addrIn;
		logic [Width-1:0] valIn;
		logic [8*128-1:0] skipBuf;
		fd = $fopen("bench/arxFilterTestdata.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/arxFilterTestdata.txt");
			errorCount++;
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %c", opChar);
				if (code == 1 && opChar == "#") begin
					code = $fgets(skipBuf, fd); // rest of a comment line.
				end else if (code == 1) begin
					code = $fscanf(fd, " %h %h", addrIn, valIn);
					opQ.push_back(opChar);
					addrQ.push_back(addrIn);
					valQ.push_back(valIn);
				end
			end
			$fclose(fd);
		end
		numOps = opQ.size();
	endtask

	task automatic runOp(input int n);
		int errsBefore;
		int gap;
		errsBefore = errorCount;
		gap = $unsigned($random(seed)) % 4;
		repeat (gap) @(negedge clk);
		@(negedge clk);
		Address = addrQ[n];
		case (opQ[n])
			"W": begin
				Write = 1'b1;
				WrDato = valQ[n];
				#(Period / 4);
				checkData("RdDato", '0, RdDato); // Read is low here.
				@(negedge clk);
				Write = 1'b0;
				@(negedge clk); // strobe is registered, give it a cycle.
			end
			"R": begin
				Read = 1'b1;
				#(Period / 4);
				checkData("RdDato", valQ[n], RdDato);
				@(negedge clk);
				Read = 1'b0;
			end
			"P": begin
				checkFlag("Listo", valQ[n][0], Listo);
				while (Listo !== 1'b1) @(negedge clk);
			end
			default: begin
				$display("unknown operation '%c' in the test data", opQ[n]);
				errorCount++;
			end
		endcase
		$display("op %0d: %c 0x%h 0x%h %s", n, opQ[n], addrQ[n], valQ[n],
			(errorCount == errsBefore) ? "ok" : "FAILED");
	endtask

	initial begin
		rst = 1'b1;
		Write = 1'b0;
		Read = 1'b0;
		Address = '0;
		WrDato = '0;
		seed = 37;
		checkCount = 0;
		errorCount = 0;
		loaded = 1'b0;
		loadOps();
		loaded = 1'b1;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < numOps; i++) begin
			runOp(i);
		end
		if (u_dut.props.failCount != 0) begin
			$display("%0d bound assertion failures on the bus ports", u_dut.props.failCount);
			errorCount += u_dut.props.failCount;
		end
		$display("ops: %0d, checks: %0d, errors: %0d", numOps, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// the watchdog is sized from the number of operations plus reset.
	initial begin
		wait (loaded === 1'b1);
		#((numOps * OpBudget + 20) * Period);
		$display("timeout: the operations did not complete in the expected time");
		$display("test failed");
		$finish;
	end

endmodule

/* arxFilter.f */
hdl/arxFilterPkg.sv
hdl/arxFilterIfs.sv
hdl/writeDecode.sv
hdl/arxExecute.sv
hdl/readbackMux.sv
hdl/arxFilterTop.sv
bench/arxFilterTb_properties.sv
bench/arxFilterTb.sv

/* bench/arxFilterTestdata.txt */
# op addr value: W writes value, R reads and expects value, P expects Listo then waits for it
# values in hex, Width 16, FracBits 8
W 00C 0100
W 010 0080
W 034 0040
W 038 FFE0
W 05C 0010
R 00C 0100
R 010 0080
R 034 0040
R 038 FFE0
R 05C 0010
R 000 0001
R 008 0000
W 004 1234
W 000 0000
W 064 5555
W 08C 7777
R 004 0000
R 000 0001
R 064 0000
R 08C 0000
R 1FC 0000
W 060 0200
P 000 0000
R 004 0210
W 060 0100
P 000 0000
R 004 0294
R 064 0210
W 060 FF00
P 000 0000
R 004 FFF3
W 060 0000
P 000 0000
R 004 FF3A
R 060 0000
R 064 FFF3
R 068 0294
R 06C 0210
R 088 0000
W 00C 7FFF
W 060 7FFF
P 000 0000
R 004 7FFF
R 008 0001
W 060 8000
P 000 0000
R 004 8000
R 008 0001
W 00C 0000
W 010 0000
W 038 0000
W 060 0001
P 000 0000
R 004 E010
R 008 0000
R 064 8000
R 068 7FFF
W 060 0002
W 014 1111
P 000 0000
R 014 0000
R 004 F814
R 000 0001
